//--- source/cart_pkg.sv
`default_nettype none

package cart_pkg;

  ////////////////////////////////////////////////////
  // Bus and memory widths
  ////////////////////////////////////////////////////

  typedef logic [23:0] snes_addr_t;  // Console bus address, bank in [23:16]
  typedef logic [23:0] rom_addr_t;   // PSRAM byte address, bit 0 picks the lane
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;   // One PSRAM word, upper lane is the even byte

  ////////////////////////////////////////////////////
  // Modes and states
  ////////////////////////////////////////////////////

  // Cartridge memory layout, set by the MCU after loading the image
  typedef enum logic [0:0] {
    MAP_HIROM = 1'b0,
    MAP_LOROM = 1'b1
  } mapper_t;

  // MCU access sequencing
  typedef enum logic [1:0] {
    IDLE   = 2'd0,  // Waiting for a request and a free slot
    ACCESS = 2'd1,  // MCU owns the PSRAM address
    FINISH = 2'd2,
    ACKED  = 2'd3   // Holding ack until the MCU drops req
  } arb_state_t;

  ////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////

  // Save RAM sits at the top of PSRAM, above any ROM image
  localparam rom_addr_t SAVERAM_BASE = 24'hE00000;

  // Address synchronizer length
  localparam int SYNC_DEPTH = 6;

endpackage

`default_nettype wire

//--- source/rom_req_if.sv
`default_nettype none

// One PSRAM access request, from the MCU side towards the memory port
interface rom_req_if;

  cart_pkg::rom_addr_t addr;
  cart_pkg::byte_t     wdata;
  logic                write;   // High for a write, low for a read
  logic                active;  // Request owns the PSRAM this cycle
  cart_pkg::byte_t     rdata;   // Lane selected by addr[0]

  modport requester (
    output addr, wdata, write, active,
    input  rdata
  );

  modport port (
    input  addr, wdata, write, active,
    output rdata
  );

endinterface

`default_nettype wire

//--- source/snes_bus_sync.sv
`default_nettype none

module snes_bus_sync #(
  parameter int DEAD_TIMEOUT = 96000
) (
  input  wire logic                 clk2,
  input  wire logic                 arst_n,
  input  wire cart_pkg::snes_addr_t snes_addr_raw,
  input  wire logic                 snes_read_n_raw,
  input  wire logic                 snes_write_n_raw,
  input  wire logic                 snes_cpu_clk_raw,
  input  wire logic                 rom_hit,
  output cart_pkg::snes_addr_t      snes_addr,
  output logic                      snes_read_n,
  output logic                      snes_write_n,
  output logic                      snes_cpu_clk,
  output logic                      rd_start,
  output logic                      cycle_end,
  output logic                      free_slot,
  output logic                      snes_dead,
  output logic                      restart
);

  localparam int CNT_W = $clog2(DEAD_TIMEOUT + 1);

  cart_pkg::snes_addr_t addr_q [cart_pkg::SYNC_DEPTH];
  logic [7:0]           rd_q;
  logic [2:0]           wr_q;
  logic [5:0]           clk_q;
  logic [5:0]           rd_f;     // Filtered read strobe history, bit 0 newest
  logic [3:0]           clk_f;
  logic                 cycle_start;
  logic                 free_strobe;
  logic [CNT_W-1:0]     dead_cnt_q;

  ////////////////////////////////////////////////////
  // Input shift registers
  ////////////////////////////////////////////////////

  // Strobes reset to their idle levels so no edge shows up after reset
  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_q  <= '1;
      wr_q  <= '1;
      clk_q <= '0;
    end else begin
      rd_q  <= {rd_q[6:0], snes_read_n_raw};
      wr_q  <= {wr_q[1:0], snes_write_n_raw};
      clk_q <= {clk_q[4:0], snes_cpu_clk_raw};
    end
  end

  always_ff @(posedge clk2) begin
    addr_q[0] <= snes_addr_raw;
    for (int i = 1; i < cart_pkg::SYNC_DEPTH; i++) begin
      addr_q[i] <= addr_q[i-1];
    end
  end

  // Two adjacent stages must agree, which drops single-cycle glitches
  assign snes_addr    = addr_q[cart_pkg::SYNC_DEPTH-1] & addr_q[cart_pkg::SYNC_DEPTH-2];
  assign snes_read_n  = rd_q[2] & rd_q[1];
  assign snes_write_n = wr_q[2] & wr_q[1];
  assign snes_cpu_clk = clk_q[2] & clk_q[1];

  ////////////////////////////////////////////////////
  // Edges and free slots
  ////////////////////////////////////////////////////

  assign rd_f  = rd_q[6:1] & rd_q[7:2];
  assign clk_f = clk_q[4:1] & clk_q[5:2];

  assign rd_start    = (rd_f == 6'b111110);  // Read strobe went low
  assign cycle_end   = (clk_f == 4'b0001);   // Clock rose
  assign cycle_start = (clk_f == 4'b1110);   // Clock fell

  // Cycles that do not touch PSRAM leave the memory free as well
  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  assign free_slot = cycle_end | free_strobe;

  ////////////////////////////////////////////////////
  // Console watchdog
  ////////////////////////////////////////////////////

  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      dead_cnt_q <= '0;
      snes_dead  <= 1'b1;   // No console until its clock is seen
      restart    <= 1'b0;
    end else begin
      restart <= 1'b0;
      if (clk_q[1]) begin
        dead_cnt_q <= '0;
        snes_dead  <= 1'b0;
        restart    <= snes_dead;  // One pulse on wake-up
      end else if (dead_cnt_q == CNT_W'(DEAD_TIMEOUT)) begin
        snes_dead <= 1'b1;
      end else begin
        dead_cnt_q <= dead_cnt_q + 1'b1;
      end
    end
  end

  restart_after_dead: assert property (
    @(posedge clk2) disable iff (!arst_n) restart |-> $past(snes_dead)
  );

endmodule

`default_nettype wire

//--- source/rom_map.sv
`default_nettype none

module rom_map (
  input  wire cart_pkg::snes_addr_t snes_addr,
  input  wire cart_pkg::mapper_t    mapper,
  input  wire cart_pkg::rom_addr_t  rom_mask,
  input  wire cart_pkg::rom_addr_t  saveram_mask,
  output cart_pkg::rom_addr_t       mapped_addr,
  output logic                      rom_hit,
  output logic                      is_writable,
  output logic                      is_rom
);

  cart_pkg::rom_addr_t rom_addr;
  cart_pkg::rom_addr_t save_offset;
  logic                is_saveram;

  always_comb begin
    if (mapper == cart_pkg::MAP_HIROM) begin
      // Banks 40+ fully, plus the upper half of the lower banks
      is_rom      = snes_addr[22] | snes_addr[15];
      rom_addr    = {2'b00, snes_addr[21:0]};
      // Banks 20-3F, offsets 6000-7FFF, 8 KB per bank
      is_saveram  = (snes_addr[22:21] == 2'b01) & (snes_addr[15:13] == 3'b011);
      save_offset = {6'd0, snes_addr[20:16], snes_addr[12:0]};
    end else begin
      is_rom      = snes_addr[15];
      rom_addr    = {2'b00, snes_addr[22:16], snes_addr[14:0]};  // 32 KB per bank
      // Banks 70-7D, lower half only
      is_saveram  = (snes_addr[22:20] == 3'b111) & (snes_addr[19:17] != 3'b111)
                    & ~snes_addr[15];
      save_offset = {5'd0, snes_addr[19:16], snes_addr[14:0]};
    end
  end

  ////////////////////////////////////////////////////
  // Final PSRAM address
  ////////////////////////////////////////////////////

  always_comb begin
    if (is_saveram) begin
      mapped_addr = cart_pkg::SAVERAM_BASE + (save_offset & saveram_mask);
    end else begin
      mapped_addr = rom_addr & rom_mask;  // Mirrors small images
    end
  end

  assign rom_hit     = is_rom | is_saveram;
  assign is_writable = is_saveram;  // Only save RAM takes console writes

endmodule

`default_nettype wire

//--- source/mcu_rom_arbiter.sv
`default_nettype none

module mcu_rom_arbiter #(
  parameter int ROM_CYCLE_LEN = 8
) (
  input  wire logic                clk2,
  input  wire logic                arst_n,
  input  wire logic                mcu_req,
  input  wire logic                mcu_write,
  input  wire cart_pkg::rom_addr_t mcu_addr,
  input  wire cart_pkg::byte_t     mcu_wdata,
  output logic                     mcu_ack,
  output cart_pkg::byte_t          mcu_rdata,
  input  wire logic                free_slot,
  input  wire logic                snes_dead,
  input  wire logic                restart,
  rom_req_if.requester             req
);

  localparam int DLY_W = $clog2(ROM_CYCLE_LEN + 1);

  cart_pkg::arb_state_t state_q;
  logic                 req_q;
  logic                 req_rise;
  logic                 pending_q;
  logic [DLY_W-1:0]     delay_q;
  cart_pkg::rom_addr_t  addr_q;
  cart_pkg::byte_t      wdata_q;
  logic                 write_q;
  cart_pkg::byte_t      rdata_q;

  assign req_rise = mcu_req & ~req_q;

  ////////////////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////////////////

  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      req_q <= 1'b0;
    end else begin
      req_q <= mcu_req;
    end
  end

  // MCU holds these stable while req is high
  always_ff @(posedge clk2) begin
    if (req_rise) begin
      addr_q  <= mcu_addr;
      wdata_q <= mcu_wdata;
      write_q <= mcu_write;
    end
  end

  ////////////////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////////////////

  always_ff @(posedge clk2 or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= cart_pkg::IDLE;
      pending_q <= 1'b0;
      delay_q   <= '0;
    end else begin
      if (req_rise) pending_q <= 1'b1;
      if (restart && state_q == cart_pkg::ACCESS) begin
        state_q <= cart_pkg::IDLE;  // Console woke mid-access, retry later
      end else begin
        case (state_q)
          cart_pkg::IDLE: begin
            if (pending_q && (free_slot || snes_dead)) begin
              state_q <= cart_pkg::ACCESS;
              delay_q <= DLY_W'(ROM_CYCLE_LEN);
            end
          end
          cart_pkg::ACCESS: begin
            delay_q <= delay_q - 1'b1;
            if (delay_q == '0) state_q <= cart_pkg::FINISH;
          end
          cart_pkg::FINISH: begin
            pending_q <= 1'b0;
            state_q   <= cart_pkg::ACKED;
          end
          cart_pkg::ACKED: begin
            if (!mcu_req) state_q <= cart_pkg::IDLE;
          end
          default: state_q <= cart_pkg::IDLE;
        endcase
      end
    end
  end

  // Last sample before FINISH is the settled word
  always_ff @(posedge clk2) begin
    if (state_q == cart_pkg::ACCESS && !write_q) begin
      rdata_q <= req.rdata;
    end
  end

  assign mcu_ack   = (state_q == cart_pkg::ACKED);
  assign mcu_rdata = rdata_q;

  assign req.addr   = addr_q;
  assign req.wdata  = wdata_q;
  assign req.write  = write_q;
  assign req.active = (state_q == cart_pkg::ACCESS);

  ack_needs_req: assert property (
    @(posedge clk2) disable iff (!arst_n) $rose(mcu_ack) |-> mcu_req
  );

endmodule

`default_nettype wire

//--- source/rom_port_mux.sv
`default_nettype none

module rom_port_mux (
  rom_req_if.port                   req,
  input  wire cart_pkg::rom_addr_t  mapped_addr,
  input  wire logic                 rom_hit,
  input  wire logic                 is_writable,
  input  wire logic                 snes_read_n,
  input  wire logic                 snes_write_n,
  input  wire logic                 snes_cpu_clk,
  input  wire cart_pkg::byte_t      snes_data_in,
  output logic [22:0]               rom_addr,
  input  wire cart_pkg::rom_word_t  rom_data_in,
  output cart_pkg::rom_word_t       rom_data_out,
  output logic                      rom_data_oe,
  output logic                      rom_we_n,
  output logic                      rom_bhe_n,
  output logic                      rom_ble_n,
  output cart_pkg::byte_t           snes_data_out,
  output logic                      snes_data_oe
);

  cart_pkg::rom_addr_t addr_sel;
  cart_pkg::byte_t     wr_byte;
  cart_pkg::byte_t     rd_byte;
  logic                console_we;
  logic                lane;       // 1 selects the low byte

  ////////////////////////////////////////////////////
  // Address owner
  ////////////////////////////////////////////////////

  assign addr_sel = req.active ? req.addr : mapped_addr;
  assign rom_addr = addr_sel[23:1];
  assign lane     = addr_sel[0];

  ////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////

  // Console writes land only in the clock-high half of the cycle
  assign console_we = is_writable & snes_cpu_clk & ~snes_write_n;

  assign rom_we_n     = req.active ? ~req.write : ~console_we;
  assign wr_byte      = req.active ? req.wdata : snes_data_in;
  assign rom_data_out = {wr_byte, wr_byte};  // Byte enables pick the lane
  assign rom_data_oe  = ~rom_we_n;

  assign rom_bhe_n = lane;
  assign rom_ble_n = ~lane;

  ////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////

  assign rd_byte = lane ? rom_data_in[7:0] : rom_data_in[15:8];

  assign req.rdata     = rd_byte;
  assign snes_data_out = rd_byte;
  assign snes_data_oe  = ~snes_read_n & rom_hit;  // ROM and save RAM reads only

endmodule

`default_nettype wire

//--- source/cart_main.sv
`default_nettype none

module cart_main #(
  parameter int ROM_CYCLE_LEN = 8,
  parameter int DEAD_TIMEOUT  = 96000
) (
  input  wire logic                 clk2,
  input  wire logic                 arst_n,
  // Console bus
  input  wire cart_pkg::snes_addr_t snes_addr_raw,
  input  wire logic                 snes_read_n_raw,
  input  wire logic                 snes_write_n_raw,
  input  wire logic                 snes_cpu_clk_raw,
  input  wire cart_pkg::byte_t      snes_data_in,
  output cart_pkg::byte_t           snes_data_out,
  output logic                      snes_data_oe,
  // Mapping setup from the MCU
  input  wire cart_pkg::mapper_t    mapper,
  input  wire cart_pkg::rom_addr_t  rom_mask,
  input  wire cart_pkg::rom_addr_t  saveram_mask,
  // MCU handshake
  input  wire logic                 mcu_req,
  input  wire logic                 mcu_write,
  input  wire cart_pkg::rom_addr_t  mcu_addr,
  input  wire cart_pkg::byte_t      mcu_wdata,
  output logic                      mcu_ack,
  output cart_pkg::byte_t           mcu_rdata,
  // PSRAM
  output logic [22:0]               rom_addr,
  input  wire cart_pkg::rom_word_t  rom_data_in,
  output cart_pkg::rom_word_t       rom_data_out,
  output logic                      rom_data_oe,
  output logic                      rom_we_n,
  output logic                      rom_bhe_n,
  output logic                      rom_ble_n
);

  cart_pkg::snes_addr_t snes_addr;
  cart_pkg::rom_addr_t  mapped_addr;
  logic                 snes_read_n;
  logic                 snes_write_n;
  logic                 snes_cpu_clk;
  logic                 free_slot;
  logic                 snes_dead;
  logic                 restart;
  logic                 rom_hit;
  logic                 is_writable;

  rom_req_if u_rom_req ();

  snes_bus_sync #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) u_bus_sync (
    .clk2, .arst_n, .snes_addr_raw, .snes_read_n_raw, .snes_write_n_raw,
    .snes_cpu_clk_raw, .rom_hit, .snes_addr, .snes_read_n, .snes_write_n,
    .snes_cpu_clk, .rd_start(), .cycle_end(), .free_slot, .snes_dead, .restart
  );

  rom_map u_rom_map (
    .snes_addr, .mapper, .rom_mask, .saveram_mask,
    .mapped_addr, .rom_hit, .is_writable, .is_rom()
  );

  mcu_rom_arbiter #(.ROM_CYCLE_LEN(ROM_CYCLE_LEN)) u_arbiter (
    .clk2, .arst_n, .mcu_req, .mcu_write, .mcu_addr, .mcu_wdata,
    .mcu_ack, .mcu_rdata, .free_slot, .snes_dead, .restart,
    .req(u_rom_req.requester)
  );

  rom_port_mux u_port_mux (
    .req(u_rom_req.port), .mapped_addr, .rom_hit, .is_writable,
    .snes_read_n, .snes_write_n, .snes_cpu_clk, .snes_data_in,
    .rom_addr, .rom_data_in, .rom_data_out, .rom_data_oe, .rom_we_n,
    .rom_bhe_n, .rom_ble_n, .snes_data_out, .snes_data_oe
  );

endmodule

`default_nettype wire

//--- tb/cart_main_tb.sv
`default_nettype none

module cart_main_tb;

  localparam int          DEAD_TIMEOUT  = 64;
  localparam int          ROM_CYCLE_LEN = 8;
  localparam int          SETTLE        = cart_pkg::SYNC_DEPTH + 2;  // Address pipe plus margin
  localparam int          CPU_HALF      = 12;  // Console clock half period in CLK2 cycles
  localparam int          WAIT_LIMIT    = 400;
  localparam logic [31:0] SEED          = 32'd65056;

  logic                 clk2 = 1'b0;
  logic                 arst_n;
  cart_pkg::snes_addr_t snes_addr_raw;
  logic                 snes_read_n_raw;
  logic                 snes_write_n_raw;
  logic                 snes_cpu_clk_raw;
  cart_pkg::byte_t      snes_data_in;
  cart_pkg::byte_t      snes_data_out;
  logic                 snes_data_oe;
  cart_pkg::mapper_t    mapper;
  cart_pkg::rom_addr_t  rom_mask;
  cart_pkg::rom_addr_t  saveram_mask;
  logic                 mcu_req;
  logic                 mcu_write;
  cart_pkg::rom_addr_t  mcu_addr;
  cart_pkg::byte_t      mcu_wdata;
  logic                 mcu_ack;
  cart_pkg::byte_t      mcu_rdata;
  logic [22:0]          rom_addr;
  cart_pkg::rom_word_t  rom_data_in = '0;
  cart_pkg::rom_word_t  rom_data_out;
  logic                 rom_data_oe;
  logic                 rom_we_n;
  logic                 rom_bhe_n;
  logic                 rom_ble_n;

  cart_pkg::rom_word_t  mem [int];  // Words written through the PSRAM port
  int                   mem_writes = 0;
  int                   err_cnt = 0;
  logic                 timed_out = 1'b0;
  logic                 cpu_clk_run = 1'b0;
  int                   half_cnt = 0;
  int                   rise_cnt = 0;
  int                   since_rise = 0;
  logic                 fell = 1'b0;
  int                   ack_rises = 0;  // Console clock state when ack was seen
  int                   ack_since = 0;

  cart_main #(.ROM_CYCLE_LEN(ROM_CYCLE_LEN), .DEAD_TIMEOUT(DEAD_TIMEOUT)) u_dut (.*);

  always #4 clk2 = ~clk2;

  //////////////////////////////////////////////////
  // PSRAM model
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Unwritten words hold a pattern of the whole word address
  function automatic cart_pkg::rom_word_t pattern_word(input logic [22:0] waddr);
    logic [31:0] x;
    x = xorshift32(SEED ^ {9'd0, waddr});
    x = xorshift32(x);
    return x[15:0];
  endfunction

  function automatic cart_pkg::rom_word_t word_at(input logic [22:0] waddr);
    if (mem.exists(int'(waddr))) return mem[int'(waddr)];
    return pattern_word(waddr);
  endfunction

  function automatic cart_pkg::byte_t byte_at(input logic [23:0] baddr);
    cart_pkg::rom_word_t w;
    w = word_at(baddr[23:1]);
    return baddr[0] ? w[7:0] : w[15:8];  // Even byte in the upper lane
  endfunction

  always @(rom_addr or mem_writes) begin
    if ($isunknown(rom_addr)) begin
      rom_data_in = '0;
    end else begin
      rom_data_in = word_at(rom_addr);
    end
  end

  always @(posedge clk2) begin : psram_write
    cart_pkg::rom_word_t w;
    if (arst_n && rom_we_n === 1'b0) begin
      w = word_at(rom_addr);
      if (!rom_bhe_n) w[15:8] = rom_data_out[15:8];
      if (!rom_ble_n) w[7:0] = rom_data_out[7:0];
      mem[int'(rom_addr)] = w;
      mem_writes++;
    end
  end

  //////////////////////////////////////////////////
  // Driver tasks
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // One CLK2 cycle with the console clock advancing when running
  task automatic tick();
    @(posedge clk2);
    since_rise++;
    fell = 1'b0;
    if (cpu_clk_run) begin
      if (half_cnt == CPU_HALF - 1) begin
        half_cnt = 0;
        snes_cpu_clk_raw <= ~snes_cpu_clk_raw;
        if (snes_cpu_clk_raw) begin
          fell = 1'b1;
        end else begin
          rise_cnt++;
          since_rise = 0;
        end
      end else begin
        half_cnt++;
      end
    end
  endtask

  // Four-phase handshake with a look at the first write strobe
  task automatic mcu_access(input logic wr, input logic [23:0] a, input cart_pkg::byte_t wd,
                            output cart_pkg::byte_t rd, output logic we_seen);
    int n;
    we_seen = 1'b0;
    rd = '0;
    tick();
    mcu_req   <= 1'b1;
    mcu_write <= wr;
    mcu_addr  <= a;
    mcu_wdata <= wd;
    n = 0;
    do begin
      tick();
      @(negedge clk2);
      if (!rom_we_n && !we_seen) begin
        we_seen = 1'b1;
        check("rom_addr", rom_addr, a[23:1]);
        check("rom_bhe_n", rom_bhe_n, a[0]);
        check("rom_ble_n", rom_ble_n, !a[0]);
        check("rom_data_oe", rom_data_oe, 1);
      end
      n++;
    end while (!mcu_ack && n < WAIT_LIMIT);
    if (!mcu_ack) begin
      $display("Timeout at %0t: mcu_ack did not rise within %0d cycles", $time, WAIT_LIMIT);
      timed_out = 1'b1;
      err_cnt++;
    end else begin
      rd = mcu_rdata;
      ack_rises = rise_cnt;
      ack_since = since_rise;
    end
    tick();
    mcu_req <= 1'b0;
    n = 0;
    do begin
      tick();
      @(negedge clk2);
      n++;
    end while (mcu_ack && n < WAIT_LIMIT);
    if (mcu_ack) begin
      $display("Timeout at %0t: mcu_ack stayed high after mcu_req fell", $time);
      timed_out = 1'b1;
      err_cnt++;
    end
  endtask

  // Address settles through the synchronizer before the strobe goes low
  task automatic console_cycle(input logic wr, input logic m, input logic [23:0] a,
                               input cart_pkg::byte_t d, output logic we_seen);
    we_seen = 1'b0;
    tick();
    mapper        <= cart_pkg::mapper_t'(m);
    snes_addr_raw <= a;
    snes_data_in  <= d;
    repeat (SETTLE) tick();
    snes_read_n_raw  <= wr;
    snes_write_n_raw <= !wr;
    snes_cpu_clk_raw <= 1'b1;
    repeat (SETTLE) begin
      tick();
      @(negedge clk2);
      if (!rom_we_n) we_seen = 1'b1;
    end
  endtask

  task automatic console_release();
    tick();
    snes_read_n_raw  <= 1'b1;
    snes_write_n_raw <= 1'b1;
    snes_cpu_clk_raw <= 1'b0;
    repeat (SETTLE) tick();
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int                  fd;
    int                  n;
    int                  fields;
    int                  test_no;
    int                  failed;
    int                  errs_before;
    int                  op;
    int                  r_req;
    logic                m;
    logic [23:0]         a;
    logic [7:0]          d;
    logic [23:0]         e;
    logic [8*160-1:0]    text_line;
    cart_pkg::byte_t     rd;
    cart_pkg::rom_word_t pw;
    logic                we_seen;

    test_no          = 0;
    failed           = 0;
    arst_n           = 1'b0;
    snes_addr_raw    = '0;
    snes_read_n_raw  = 1'b1;
    snes_write_n_raw = 1'b1;
    snes_cpu_clk_raw = 1'b0;
    snes_data_in     = '0;
    mapper           = cart_pkg::MAP_HIROM;
    rom_mask         = 24'h3FFFFF;  // 4 MB image
    saveram_mask     = 24'h001FFF;  // 8 KB save RAM
    mcu_req          = 1'b0;
    mcu_write        = 1'b0;
    mcu_addr         = '0;
    mcu_wdata        = '0;
    repeat (3) @(posedge clk2);
    arst_n <= 1'b1;

    fd = $fopen("tb/cart_main_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/cart_main_tests.txt");
      err_cnt++;
    end else begin
      while (!timed_out && $fgets(text_line, fd) > 0) begin
        fields = $sscanf(text_line, "%h %h %h %h %h", op, m, a, d, e);
        if (fields == 5) begin
          errs_before = err_cnt;
          test_no++;
          case (op)
            0: begin
              tick();
              @(negedge clk2);
              check("mcu_ack", mcu_ack, 0);
              check("rom_we_n", rom_we_n, 1);
              check("rom_data_oe", rom_data_oe, 0);
              check("snes_data_oe", snes_data_oe, 0);
            end
            1: begin
              console_cycle(1'b0, m, a, d, we_seen);
              check("rom_addr", rom_addr, e[23:1]);
              check("snes_data_oe", snes_data_oe, 1);
              check("snes_data_out", snes_data_out, byte_at(e));
              console_release();
            end
            2: begin
              mcu_access(1'b0, a, 8'h00, rd, we_seen);
              check("rom_we_n strobe", we_seen, 0);
              check("mcu_rdata", rd, byte_at(a));
            end
            3: begin
              mcu_access(1'b1, a, d, rd, we_seen);
              check("rom_we_n strobe", we_seen, 1);
              mcu_access(1'b0, a, 8'h00, rd, we_seen);
              check("mcu_rdata", rd, e[7:0]);
            end
            4, 5: begin
              console_cycle(1'b1, m, a, d, we_seen);
              console_release();
              check("rom_we_n strobe", we_seen, op == 4);
              pw = pattern_word(e[23:1]);
              if (op == 4) begin
                check("saved byte", byte_at(e), d);
              end else begin
                check("rom byte", byte_at(e), e[0] ? pw[7:0] : pw[15:8]);
              end
            end
            6: begin
              tick();
              mapper        <= cart_pkg::mapper_t'(m);
              snes_addr_raw <= a;
              cpu_clk_run = 1'b1;
              half_cnt    = 0;
              r_req       = rise_cnt + 2;
              n           = 0;
              do begin
                tick();
                n++;
              end while (!(rise_cnt >= r_req && fell) && n < WAIT_LIMIT);
              if (!(rise_cnt >= r_req && fell)) begin
                $display("Timeout at %0t: console clock never settled", $time);
                timed_out = 1'b1;
                err_cnt++;
              end else begin
                r_req = rise_cnt;  // Request goes out in the low half
                mcu_access(1'b0, e, 8'h00, rd, we_seen);
                check("mcu_ack after cycle end",
                      ack_rises > r_req && ack_since >= 4 + ROM_CYCLE_LEN + 1, 1);
                check("mcu_rdata", rd, byte_at(e));
              end
              cpu_clk_run = 1'b0;
              tick();
              snes_cpu_clk_raw <= 1'b0;
            end
            default: begin
              $display("Unknown operation %0d in test %0d", op, test_no);
              err_cnt++;
            end
          endcase
          if (err_cnt == errs_before) begin
            $display("test %0d (op %0d): ok", test_no, op);
          end else begin
            $display("test %0d (op %0d): failed", test_no, op);
            failed++;
          end
        end
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             test_no, test_no - failed, failed, err_cnt);
    if (err_cnt == 0 && test_no > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cart_main.f
source/cart_pkg.sv
source/rom_req_if.sv
source/snes_bus_sync.sv
source/rom_map.sv
source/mcu_rom_arbiter.sv
source/rom_port_mux.sv
source/cart_main.sv
tb/cart_main_tb.sv

//--- Bender.yml
package:
  name: cart_main

sources:
  - source/cart_pkg.sv
  - source/rom_req_if.sv
  - source/snes_bus_sync.sv
  - source/rom_map.sv
  - source/mcu_rom_arbiter.sv
  - source/rom_port_mux.sv
  - source/cart_main.sv
  - target: test
    files:
      - tb/cart_main_tb.sv

//--- tb/cart_main_tests.txt
# op mapper addr data expect, all hex; mapper 0 HiROM, 1 LoROM; op 0 idle, 1 console read
# 2 MCU read, 3 MCU write+read, 4 save RAM write, 5 ROM write, 6 MCU read of expect, clock live
0 0 000000 00 000000
1 1 018123 00 008123
1 1 8ffffe 00 07fffe
1 0 c12345 00 012345
1 0 008001 00 008001
1 1 701234 00 e01234
1 0 306abc 00 e00abc
2 0 012345 00 000000
2 0 200001 00 000000
3 0 100010 a5 0000a5
3 0 100011 3c 00003c
4 1 701234 5a e01234
4 0 216001 c3 e00001
5 1 008000 ff 000000
5 0 c00010 77 000010
6 1 008000 00 0200ab
6 0 c00000 00 100010
